// File: backend_top.f
design/core_pkg.sv
design/bus_pkg.sv
design/wb_bus_if.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/data_ram.sv
design/writeback_stage.sv
design/register_file.sv
design/backend_top.sv
tb/backend_sva.sv
tb/backend_tb.sv

// File: Makefile
# Verilator build and run for the back end testbench

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= backend_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/backend_tb.sv
// Directed testbench for the back end: execute-side driver, host bus master,
// register and counter models, compare tasks and the final report
`default_nettype none

module backend_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;
  import bus_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic      clk_i;
  logic      rst_ni;
  logic      issue_valid_i;
  wb_kind_e  issue_kind_i;
  pc_t       issue_pc_i;
  logic      issue_compressed_i;
  logic      issue_count_i;
  reg_addr_t issue_rd_i;
  data_t     issue_rd_data_i;
  logic      issue_rd_we_i;
  logic      issue_fp_i;
  bus_addr_t issue_addr_i;
  data_t     issue_store_data_i;
  logic      ready_o;
  logic      instr_done_o;
  pc_t       pc_wb_o;
  logic      rf_write_pending_o;
  logic      outstanding_load_o;
  logic      outstanding_store_o;
  count_t    retired_o;
  count_t    retired_compressed_o;
  logic      host_cyc_i;
  logic      host_stb_i;
  logic      host_we_i;
  bus_addr_t host_adr_i;
  bus_data_t host_dat_i;
  bus_data_t host_dat_o;
  logic      host_ack_o;
  logic      host_err_o;
  reg_addr_t rf_raddr_i;
  logic      rf_fp_i;
  data_t     rf_rdata_o;

  // Reference state kept alongside the DUT
  data_t     int_model [NUM_REGS];
  data_t     fp_model  [NUM_REGS];
  bus_data_t mem_model [RAM_WORDS];
  count_t    retired_model;
  count_t    compressed_model;
  int        check_errors;
  int        timeout_errors;
  integer    seed;

  backend_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      check_errors++;
    end
  endtask

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(1 + ($unsigned($random(seed)) % 31));
  endfunction

  function automatic bus_addr_t rand_addr();
    return bus_addr_t'(($unsigned($random(seed)) % RAM_WORDS) * 4);
  endfunction

  // Holds the issue fields until the acceptance edge
  task automatic drive_issue(input wb_kind_e kind, input pc_t pc, input logic compressed,
                             input logic count, input reg_addr_t rd, input data_t data,
                             input logic rd_we, input logic fp, input bus_addr_t addr,
                             input data_t sdata);
    int waited;
    waited = 0;
    @(posedge clk_i);
    issue_valid_i      <= 1'b1;
    issue_kind_i       <= kind;
    issue_pc_i         <= pc;
    issue_compressed_i <= compressed;
    issue_count_i      <= count;
    issue_rd_i         <= rd;
    issue_rd_data_i    <= data;
    issue_rd_we_i      <= rd_we;
    issue_fp_i         <= fp;
    issue_addr_i       <= addr;
    issue_store_data_i <= sdata;
    @(negedge clk_i);
    while (!ready_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ready_o) begin
      $display("Timeout: instruction at pc 0x%h was never accepted", pc);
      timeout_errors++;
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
  endtask

  task automatic await_done(output pc_t pc, output logic saw_load, output logic saw_store);
    int waited;
    waited    = 0;
    saw_load  = 1'b0;
    saw_store = 1'b0;
    pc        = '0;
    @(negedge clk_i);
    while (!instr_done_o && waited < TIMEOUT_CYCLES) begin
      saw_load  = saw_load | outstanding_load_o;
      saw_store = saw_store | outstanding_store_o;
      @(negedge clk_i);
      waited++;
    end
    if (instr_done_o) begin
      pc        = pc_wb_o;
      saw_load  = saw_load | outstanding_load_o;
      saw_store = saw_store | outstanding_store_o;
    end else begin
      $display("Timeout: no instruction completed in writeback");
      timeout_errors++;
    end
  endtask

  task automatic host_access(input logic we, input bus_addr_t adr, input bus_data_t wdat,
                             output bus_data_t rdat, output logic err);
    int waited;
    waited = 0;
    @(posedge clk_i);
    host_cyc_i <= 1'b1;
    host_stb_i <= 1'b1;
    host_we_i  <= we;
    host_adr_i <= adr;
    host_dat_i <= wdat;
    @(negedge clk_i);
    while (!(host_ack_o || host_err_o) && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(host_ack_o || host_err_o)) begin
      $display("Timeout: host access to 0x%h got no response", adr);
      timeout_errors++;
    end
    rdat = host_dat_o;
    err  = host_err_o;
    @(posedge clk_i);
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
    host_we_i  <= 1'b0;
  endtask

  task automatic read_reg(input logic fp, input reg_addr_t addr, input data_t exp);
    @(posedge clk_i);
    rf_raddr_i <= addr;
    rf_fp_i    <= fp;
    @(negedge clk_i);
    check_data(fp ? "rf_rdata_o (fp)" : "rf_rdata_o (int)", rf_rdata_o, exp);
  endtask

  task automatic host_write(input bus_addr_t adr, input bus_data_t data);
    bus_data_t rdat;
    logic      err;
    host_access(1'b1, adr, data, rdat, err);
    check_flag("host_err_o", err, 1'b0);
    mem_model[adr[RAM_IDX_W+1:2]] = data;
  endtask

  task automatic test_alu_write();
    reg_addr_t rd;
    data_t     data;
    pc_t       pc;
    logic      sl;
    logic      ss;
    rd   = rand_reg();
    data = data_t'($random(seed));
    drive_issue(WB_OTHER, 32'h100, 1'b0, 1'b1, rd, data, 1'b1, 1'b0, '0, '0);
    // An OTHER instruction finishes in the cycle right after acceptance
    @(negedge clk_i);
    check_flag("instr_done_o", instr_done_o, 1'b1);
    check_data("pc_wb_o", data_t'(pc_wb_o), 32'h100);
    check_flag("rf_write_pending_o", rf_write_pending_o, 1'b1);
    int_model[rd] = data;
    retired_model++;
    read_reg(1'b0, rd, int_model[rd]);
    check_flag("instr_done_o", instr_done_o, 1'b0);
    drive_issue(WB_OTHER, 32'h104, 1'b0, 1'b1, '0, 32'hdead_beef, 1'b1, 1'b0, '0, '0);
    await_done(pc, sl, ss);
    retired_model++;
    read_reg(1'b0, '0, '0);
    check_count("retired_o", retired_o, retired_model);
  endtask

  task automatic test_loads();
    bus_addr_t addr;
    bus_data_t word;
    reg_addr_t rd;
    pc_t       pc;
    logic      sl;
    logic      ss;
    addr = rand_addr();
    word = bus_data_t'($random(seed));
    host_write(addr, word);
    for (int fp = 0; fp < 2; fp++) begin
      rd = rand_reg();
      drive_issue(WB_LOAD, 32'h200 + fp * 4, 1'b0, 1'b1, rd, '0, 1'b1, fp[0], addr, '0);
      await_done(pc, sl, ss);
      check_flag("outstanding_load_o", sl, 1'b1);
      check_flag("rf_write_pending_o", rf_write_pending_o, 1'b1);
      check_data("pc_wb_o", data_t'(pc), 32'h200 + fp * 4);
      if (fp == 0) begin
        int_model[rd] = word;
      end else begin
        fp_model[rd] = word;
      end
      retired_model++;
      read_reg(1'b0, rd, int_model[rd]);
      read_reg(1'b1, rd, fp_model[rd]);
      check_flag("outstanding_load_o", outstanding_load_o, 1'b0);
    end
  endtask

  task automatic test_store();
    bus_addr_t addr;
    bus_data_t word;
    bus_data_t rdat;
    logic      err;
    pc_t       pc;
    logic      sl;
    logic      ss;
    addr = rand_addr();
    word = bus_data_t'($random(seed));
    drive_issue(WB_STORE, 32'h300, 1'b0, 1'b1, '0, '0, 1'b0, 1'b0, addr, word);
    await_done(pc, sl, ss);
    check_flag("outstanding_store_o", ss, 1'b1);
    // A store without a destination has no register write in flight
    check_flag("rf_write_pending_o", rf_write_pending_o, 1'b0);
    mem_model[addr[RAM_IDX_W+1:2]] = word;
    retired_model++;
    host_access(1'b0, addr, '0, rdat, err);
    check_data("host_dat_o", rdat, mem_model[addr[RAM_IDX_W+1:2]]);
  endtask

  task automatic test_backpressure();
    bus_addr_t addr;
    reg_addr_t rd_ld;
    reg_addr_t rd_alu;
    data_t     data;
    pc_t       pc;
    logic      sl;
    logic      ss;
    addr   = rand_addr();
    host_write(addr, bus_data_t'($random(seed)));
    rd_ld  = rand_reg();
    rd_alu = (rd_ld == 5'd31) ? 5'd1 : rd_ld + 5'd1;
    data   = data_t'($random(seed));
    drive_issue(WB_LOAD, 32'h400, 1'b0, 1'b1, rd_ld, '0, 1'b1, 1'b0, addr, '0);
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b0);
    fork
      drive_issue(WB_OTHER, 32'h404, 1'b0, 1'b1, rd_alu, data, 1'b1, 1'b0, '0, '0);
      begin
        await_done(pc, sl, ss);
        check_data("pc_wb_o (load)", data_t'(pc), 32'h400);
        await_done(pc, sl, ss);
        check_data("pc_wb_o (alu)", data_t'(pc), 32'h404);
      end
    join
    int_model[rd_ld]  = mem_model[addr[RAM_IDX_W+1:2]];
    int_model[rd_alu] = data;
    retired_model += 2;
    read_reg(1'b0, rd_ld, int_model[rd_ld]);
    read_reg(1'b0, rd_alu, int_model[rd_alu]);
  endtask

  task automatic test_arbitration();
    bus_addr_t addr_ld;
    bus_addr_t addr_host;
    bus_data_t rdat;
    logic      err;
    reg_addr_t rd;
    pc_t       pc;
    logic      sl;
    logic      ss;
    addr_ld   = rand_addr();
    addr_host = rand_addr();
    host_write(addr_ld, bus_data_t'($random(seed)));
    host_write(addr_host, bus_data_t'($random(seed)));
    rd = rand_reg();
    // Both masters raise their request in the same cycle
    fork
      begin
        drive_issue(WB_LOAD, 32'h500, 1'b0, 1'b1, rd, '0, 1'b1, 1'b0, addr_ld, '0);
        await_done(pc, sl, ss);
      end
      begin
        @(posedge clk_i);
        host_access(1'b0, addr_host, '0, rdat, err);
      end
    join
    check_data("host_dat_o", rdat, mem_model[addr_host[RAM_IDX_W+1:2]]);
    int_model[rd] = mem_model[addr_ld[RAM_IDX_W+1:2]];
    retired_model++;
    read_reg(1'b0, rd, int_model[rd]);
  endtask

  task automatic test_error_load();
    reg_addr_t rd;
    pc_t       pc;
    logic      sl;
    logic      ss;
    rd = rand_reg();
    drive_issue(WB_LOAD, 32'h600, 1'b1, 1'b1, rd, '0, 1'b1, 1'b0, 32'h0000_1000, '0);
    await_done(pc, sl, ss);
    read_reg(1'b0, rd, int_model[rd]);
    read_reg(1'b1, rd, fp_model[rd]);
    check_count("retired_o", retired_o, retired_model);
    drive_issue(WB_OTHER, 32'h604, 1'b1, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0);
    await_done(pc, sl, ss);
    drive_issue(WB_OTHER, 32'h606, 1'b1, 1'b1, '0, '0, 1'b0, 1'b0, '0, '0);
    await_done(pc, sl, ss);
    retired_model++;
    compressed_model++;
    @(negedge clk_i);
    check_count("retired_o", retired_o, retired_model);
    check_count("retired_compressed_o", retired_compressed_o, compressed_model);
  endtask

  initial begin
    seed               = 62;
    check_errors       = 0;
    timeout_errors     = 0;
    retired_model      = '0;
    compressed_model   = '0;
    rst_ni             = 1'b0;
    issue_valid_i      = 1'b0;
    issue_kind_i       = WB_OTHER;
    issue_pc_i         = '0;
    issue_compressed_i = 1'b0;
    issue_count_i      = 1'b0;
    issue_rd_i         = '0;
    issue_rd_data_i    = '0;
    issue_rd_we_i      = 1'b0;
    issue_fp_i         = 1'b0;
    issue_addr_i       = '0;
    issue_store_data_i = '0;
    host_cyc_i         = 1'b0;
    host_stb_i         = 1'b0;
    host_we_i          = 1'b0;
    host_adr_i         = '0;
    host_dat_i         = '0;
    rf_raddr_i         = '0;
    rf_fp_i            = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      int_model[i] = '0;
      fp_model[i]  = '0;
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b1);
    test_alu_write();
    test_loads();
    test_store();
    test_backpressure();
    test_arbitration();
    test_error_load();
    $display("Check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/backend_sva.sv
// Bound assertions on writeback write enables and arbiter bus rules
`default_nettype none

module backend_sva (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       int_we_i,
  input  logic       fp_we_i,
  input  logic       cyc_i,
  input  logic       ack_i,
  input  logic       err_i,
  input  logic [1:0] grant_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // A retired value goes to exactly one register file
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(int_we_i && fp_we_i))
    else $error("integer and FP write enables high together");

  assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |-> cyc_i)
    else $error("ack seen without cyc");

  // Grant is held until the slave ends the cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (grant_i != 2'd0 && !ack_i && !err_i) |=> (grant_i == $past(grant_i)))
    else $error("grant changed before ack or err");

endmodule

bind writeback_stage backend_sva u_wb_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .int_we_i (int_we_o),
  .fp_we_i  (fp_we_o),
  .cyc_i    (1'b0),
  .ack_i    (1'b0),
  .err_i    (1'b0),
  .grant_i  (2'd0)
);

bind bus_arbiter backend_sva u_arb_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .int_we_i (1'b0),
  .fp_we_i  (1'b0),
  .cyc_i    (ram_bus.cyc),
  .ack_i    (ram_bus.ack),
  .err_i    (ram_bus.err),
  .grant_i  (grant_q)
);

`default_nettype wire

// File: design/backend_top.sv
// Back end top level: issue port, writeback stage, load/store unit,
// host port, arbiter, data RAM and register files
`default_nettype none

module backend_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                issue_valid_i,
  input  core_pkg::wb_kind_e  issue_kind_i,
  input  core_pkg::pc_t       issue_pc_i,
  input  logic                issue_compressed_i,
  input  logic                issue_count_i,
  input  core_pkg::reg_addr_t issue_rd_i,
  input  core_pkg::data_t     issue_rd_data_i,
  input  logic                issue_rd_we_i,
  input  logic                issue_fp_i,
  input  bus_pkg::bus_addr_t  issue_addr_i,
  input  core_pkg::data_t     issue_store_data_i,
  output logic                ready_o,

  output logic                instr_done_o,
  output core_pkg::pc_t       pc_wb_o,
  output logic                rf_write_pending_o,
  output logic                outstanding_load_o,
  output logic                outstanding_store_o,
  output core_pkg::count_t    retired_o,
  output core_pkg::count_t    retired_compressed_o,

  input  logic                host_cyc_i,
  input  logic                host_stb_i,
  input  logic                host_we_i,
  input  bus_pkg::bus_addr_t  host_adr_i,
  input  bus_pkg::bus_data_t  host_dat_i,
  output bus_pkg::bus_data_t  host_dat_o,
  output logic                host_ack_o,
  output logic                host_err_o,

  input  core_pkg::reg_addr_t rf_raddr_i,
  input  logic                rf_fp_i,
  output core_pkg::data_t     rf_rdata_o
);

  import core_pkg::*;

  logic      wb_ready;
  logic      accept;
  logic      lsu_resp_valid;
  logic      lsu_resp_err;
  data_t     lsu_rdata;
  logic      rf_int_we;
  logic      rf_fp_we;
  reg_addr_t rf_waddr;
  data_t     rf_wdata;

  wb_bus_if lsu_bus ();
  wb_bus_if host_bus ();
  wb_bus_if ram_bus ();

  // Host pins form the second bus master
  assign host_bus.cyc   = host_cyc_i;
  assign host_bus.stb   = host_stb_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.adr   = host_adr_i;
  assign host_bus.dat_w = host_dat_i;
  assign host_dat_o     = host_bus.dat_r;
  assign host_ack_o     = host_bus.ack;
  assign host_err_o     = host_bus.err;

  assign accept  = issue_valid_i & wb_ready;
  assign ready_o = wb_ready;

  load_store_unit u_lsu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (accept),
    .kind_i       (issue_kind_i),
    .addr_i       (issue_addr_i),
    .wdata_i      (issue_store_data_i),
    .bus          (lsu_bus.master),
    .resp_valid_o (lsu_resp_valid),
    .resp_err_o   (lsu_resp_err),
    .rdata_o      (lsu_rdata)
  );

  bus_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .lsu_bus  (lsu_bus.slave),
    .host_bus (host_bus.slave),
    .ram_bus  (ram_bus.master)
  );

  data_ram u_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (ram_bus.slave)
  );

  writeback_stage u_wb (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .en_i                 (accept),
    .kind_i               (issue_kind_i),
    .pc_i                 (issue_pc_i),
    .compressed_i         (issue_compressed_i),
    .count_i              (issue_count_i),
    .rd_i                 (issue_rd_i),
    .rd_data_i            (issue_rd_data_i),
    .rd_we_i              (issue_rd_we_i),
    .fp_i                 (issue_fp_i),
    .lsu_valid_i          (lsu_resp_valid),
    .lsu_err_i            (lsu_resp_err),
    .lsu_rdata_i          (lsu_rdata),
    .ready_o              (wb_ready),
    .done_o               (instr_done_o),
    .pc_o                 (pc_wb_o),
    .rf_write_pending_o   (rf_write_pending_o),
    .outstanding_load_o   (outstanding_load_o),
    .outstanding_store_o  (outstanding_store_o),
    .int_we_o             (rf_int_we),
    .fp_we_o              (rf_fp_we),
    .waddr_o              (rf_waddr),
    .wdata_o              (rf_wdata),
    .retired_o            (retired_o),
    .retired_compressed_o (retired_compressed_o)
  );

  register_file u_rf (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .int_we_i (rf_int_we),
    .fp_we_i  (rf_fp_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr_i  (rf_raddr_i),
    .rfp_i    (rf_fp_i),
    .rdata_o  (rf_rdata_o)
  );

endmodule

`default_nettype wire

// File: design/register_file.sv
// Integer and single-precision FP register files, one shared write address
// and one combinational debug read port
`default_nettype none

module register_file (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                int_we_i,
  input  logic                fp_we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::data_t     wdata_i,
  input  core_pkg::reg_addr_t raddr_i,
  input  logic                rfp_i,
  output core_pkg::data_t     rdata_o
);

  import core_pkg::*;

  data_t int_regs [NUM_REGS];
  data_t fp_regs  [NUM_REGS];

  // x0 is never written, so after reset it reads zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        int_regs[i] <= '0;
      end
    end else if (int_we_i && (waddr_i != '0)) begin
      int_regs[waddr_i] <= wdata_i;
    end
  end

  // f0 is an ordinary register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        fp_regs[i] <= '0;
      end
    end else if (fp_we_i) begin
      fp_regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_o = rfp_i ? fp_regs[raddr_i] : int_regs[raddr_i];

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
// Writeback stage: holds the accepted instruction, picks ALU or load data,
// steers it to the integer or FP file and counts retired instructions
`default_nettype none

module writeback_stage (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               en_i,
  input  core_pkg::wb_kind_e kind_i,
  input  core_pkg::pc_t      pc_i,
  input  logic               compressed_i,
  input  logic               count_i,

  input  core_pkg::reg_addr_t rd_i,
  input  core_pkg::data_t    rd_data_i,
  input  logic               rd_we_i,
  input  logic               fp_i,

  input  logic               lsu_valid_i,
  input  logic               lsu_err_i,
  input  core_pkg::data_t    lsu_rdata_i,

  output logic               ready_o,
  output logic               done_o,
  output core_pkg::pc_t      pc_o,
  output logic               rf_write_pending_o,
  output logic               outstanding_load_o,
  output logic               outstanding_store_o,

  output logic               int_we_o,
  output logic               fp_we_o,
  output core_pkg::reg_addr_t waddr_o,
  output core_pkg::data_t    wdata_o,

  output core_pkg::count_t   retired_o,
  output core_pkg::count_t   retired_compressed_o
);

  import core_pkg::*;

  logic      valid_q;
  logic      done;
  logic      alu_we;
  logic      load_we;
  logic      retire;

  wb_kind_e  kind_q;
  pc_t       pc_q;
  logic      compressed_q;
  logic      count_q;
  reg_addr_t rd_q;
  data_t     rd_data_q;
  logic      rd_we_q;
  logic      fp_q;

  count_t    retired_q;
  count_t    retired_c_q;

  // OTHER finishes at once, loads and stores wait for the LSU response
  assign done    = (kind_q == WB_OTHER) | lsu_valid_i;
  assign ready_o = ~valid_q | done;
  assign done_o  = valid_q & done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= en_i | (valid_q & ~done);
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      kind_q       <= kind_i;
      pc_q         <= pc_i;
      compressed_q <= compressed_i;
      count_q      <= count_i;
      rd_q         <= rd_i;
      rd_data_q    <= rd_data_i;
      rd_we_q      <= rd_we_i;
      fp_q         <= fp_i;
    end
  end

  assign alu_we  = valid_q & rd_we_q & (kind_q == WB_OTHER);
  // an erroring load leaves the register untouched
  assign load_we = valid_q & (kind_q == WB_LOAD) & lsu_valid_i & ~lsu_err_i;

  assign wdata_o  = load_we ? lsu_rdata_i : rd_data_q;
  assign waddr_o  = rd_q;
  assign int_we_o = (alu_we | load_we) & ~fp_q;
  assign fp_we_o  = (alu_we | load_we) & fp_q;

  assign pc_o                = pc_q;
  assign rf_write_pending_o  = valid_q & (rd_we_q | (kind_q == WB_LOAD));
  assign outstanding_load_o  = valid_q & (kind_q == WB_LOAD);
  assign outstanding_store_o = valid_q & (kind_q == WB_STORE);

  // Bus errors do not count as retired
  assign retire = done_o & count_q & ~(lsu_valid_i & lsu_err_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retired_q   <= '0;
      retired_c_q <= '0;
    end else if (retire) begin
      retired_q <= retired_q + count_t'(1);
      if (compressed_q) begin
        retired_c_q <= retired_c_q + count_t'(1);
      end
    end
  end

  assign retired_o            = retired_q;
  assign retired_compressed_o = retired_c_q;

endmodule

`default_nettype wire

// File: design/data_ram.sv
// Word RAM on a Wishbone slave port, err for out-of-range addresses
`default_nettype none

module data_ram (
  input  logic     clk_i,
  input  logic     rst_ni,
  wb_bus_if.slave  bus
);

  import bus_pkg::*;

  bus_data_t mem [RAM_WORDS];
  bus_data_t rdata_q;
  ram_idx_t  idx;
  logic      in_range;
  logic      req_new;
  logic      ack_q;
  logic      err_q;

  assign idx      = bus.adr[RAM_IDX_W+1:2];
  assign in_range = (bus.adr < RAM_BYTES);

  // A strobe is new unless it is the one being answered this cycle
  assign req_new  = bus.cyc & bus.stb & ~ack_q & ~err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req_new & in_range;
      err_q <= req_new & ~in_range;
    end
  end

  // Write lands on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (req_new & in_range) begin
      if (bus.we) begin
        mem[idx] <= bus.dat_w;
      end
      rdata_q <= mem[idx];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.dat_r = rdata_q;

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
// Fixed-priority arbiter placing the load/store unit and the host port in
// front of a single Wishbone slave
`default_nettype none

module bus_arbiter (
  input  logic      clk_i,
  input  logic      rst_ni,
  wb_bus_if.slave   lsu_bus,
  wb_bus_if.slave   host_bus,
  wb_bus_if.master  ram_bus
);

  import bus_pkg::*;

  grant_e grant_q;
  grant_e sel;

  // An idle bus grants combinationally, the LSU wins a tie
  always_comb begin
    sel = grant_q;
    if (grant_q == GNT_NONE) begin
      if (lsu_bus.cyc & lsu_bus.stb) begin
        sel = GNT_LSU;
      end else if (host_bus.cyc & host_bus.stb) begin
        sel = GNT_HOST;
      end
    end
  end

  // The grant is held until the slave ends the cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      grant_q <= GNT_NONE;
    end else if (ram_bus.ack | ram_bus.err) begin
      grant_q <= GNT_NONE;
    end else begin
      grant_q <= sel;
    end
  end

  always_comb begin
    ram_bus.cyc    = 1'b0;
    ram_bus.stb    = 1'b0;
    ram_bus.we     = 1'b0;
    ram_bus.adr    = '0;
    ram_bus.dat_w  = '0;
    lsu_bus.ack    = 1'b0;
    lsu_bus.err    = 1'b0;
    lsu_bus.dat_r  = '0;
    host_bus.ack   = 1'b0;
    host_bus.err   = 1'b0;
    host_bus.dat_r = '0;
    case (sel)
      GNT_LSU: begin
        ram_bus.cyc   = lsu_bus.cyc;
        ram_bus.stb   = lsu_bus.stb;
        ram_bus.we    = lsu_bus.we;
        ram_bus.adr   = lsu_bus.adr;
        ram_bus.dat_w = lsu_bus.dat_w;
        lsu_bus.ack   = ram_bus.ack;
        lsu_bus.err   = ram_bus.err;
        lsu_bus.dat_r = ram_bus.dat_r;
      end
      GNT_HOST: begin
        ram_bus.cyc    = host_bus.cyc;
        ram_bus.stb    = host_bus.stb;
        ram_bus.we     = host_bus.we;
        ram_bus.adr    = host_bus.adr;
        ram_bus.dat_w  = host_bus.dat_w;
        host_bus.ack   = ram_bus.ack;
        host_bus.err   = ram_bus.err;
        host_bus.dat_r = ram_bus.dat_r;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/load_store_unit.sv
// Load/store unit: one Wishbone cycle per issued load or store, with the
// response handed back to writeback in the ack or err cycle
`default_nettype none

module load_store_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  core_pkg::wb_kind_e  kind_i,
  input  bus_pkg::bus_addr_t  addr_i,
  input  core_pkg::data_t     wdata_i,
  wb_bus_if.master            bus,
  output logic                resp_valid_o,
  output logic                resp_err_o,
  output core_pkg::data_t     rdata_o
);

  import core_pkg::*;
  import bus_pkg::*;

  typedef enum logic {LSU_IDLE, LSU_BUSY} lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       is_mem_op;
  logic       bus_done;
  logic       take_req;

  // Held request and the last word read back
  logic       we_q;
  bus_addr_t  adr_q;
  bus_data_t  dat_w_q;
  data_t      rdata_q;

  assign is_mem_op = (kind_i == WB_LOAD) | (kind_i == WB_STORE);
  assign bus_done  = (state_q == LSU_BUSY) & (bus.ack | bus.err);

  // A new request may enter in the same cycle the current one completes
  assign take_req  = start_i & is_mem_op & ((state_q == LSU_IDLE) | bus_done);

  always_comb begin
    state_d = state_q;
    if (take_req) begin
      state_d = LSU_BUSY;
    end else if (bus_done) begin
      state_d = LSU_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_req) begin
      we_q    <= (kind_i == WB_STORE);
      adr_q   <= addr_i;
      dat_w_q <= wdata_i;
    end
    if (bus_done & bus.ack) begin
      rdata_q <= bus.dat_r;
    end
  end

  // Request signals stay stable for the whole cycle
  assign bus.cyc   = (state_q == LSU_BUSY);
  assign bus.stb   = (state_q == LSU_BUSY);
  assign bus.we    = we_q;
  assign bus.adr   = adr_q;
  assign bus.dat_w = dat_w_q;

  assign resp_valid_o = bus_done;
  assign resp_err_o   = bus_done & bus.err;

  // Bus data in the ack cycle, then the captured word stays on the output
  assign rdata_o = (bus_done & bus.ack) ? bus.dat_r : rdata_q;

endmodule

`default_nettype wire

// File: design/wb_bus_if.sv
// Wishbone classic bus with master and slave views
`default_nettype none

interface wb_bus_if;

  logic               cyc;
  logic               stb;
  logic               we;
  bus_pkg::bus_addr_t adr;
  bus_pkg::bus_data_t dat_w;
  bus_pkg::bus_data_t dat_r;
  logic               ack;
  logic               err;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

// File: design/bus_pkg.sv
// Wishbone address and data types, RAM geometry and arbiter grant states
`default_nettype none

package bus_pkg;

  localparam int unsigned BUS_ADDR_W = 32;
  localparam int unsigned BUS_DATA_W = 32;

  // Word-addressed RAM, anything at or above RAM_BYTES answers with err
  localparam int unsigned RAM_WORDS  = 256;
  localparam int unsigned RAM_IDX_W  = $clog2(RAM_WORDS);
  localparam int unsigned RAM_BYTES  = RAM_WORDS * (BUS_DATA_W / 8);

  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_data_t;
  typedef logic [RAM_IDX_W-1:0]  ram_idx_t;

  typedef enum logic [1:0] {GNT_NONE, GNT_LSU, GNT_HOST} grant_e;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
// Core-side types and sizes: register indices, data words, program counter,
// writeback instruction kinds and retire counters
`default_nettype none

package core_pkg;

  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned PC_W       = 32;
  localparam int unsigned COUNT_W    = 16;

  // Both register files have one entry per register index
  localparam int unsigned NUM_REGS   = 2 ** REG_ADDR_W;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [PC_W-1:0]       pc_t;
  typedef logic [COUNT_W-1:0]    count_t;

  // What the instruction in writeback still waits for
  typedef enum logic [1:0] {
    WB_OTHER = 2'd0,
    WB_LOAD  = 2'd1,
    WB_STORE = 2'd2
  } wb_kind_e;

endpackage

`default_nettype wire
